// File: soc_pkg.sv
`default_nettype none

package soc_pkg;

    typedef logic [31:0] addr_t; // byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  be_t;   // one bit per byte lane

    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_GPIO,
        SEL_TICK,
        SEL_NONE
    } slave_sel_e;

    // address map
    parameter addr_t RAM_BASE  = 32'h0000_0000;
    parameter addr_t GPIO_BASE = 32'h1FD0_F000;
    parameter addr_t TICK_BASE = 32'h1FD0_F100;

    // gpio register offsets
    parameter logic [7:0] GPIO_OUT_OFS = 8'h00;
    parameter logic [7:0] GPIO_IN_OFS  = 8'h04;

    parameter int SEG_DIGITS = 8;

endpackage

`default_nettype wire

// File: dbus_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module dbus_decoder #(
    parameter int RAM_WORDS = 256
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire soc_pkg::addr_t    bus_addr_i,
    input  wire                    bus_rd_i,
    input  wire                    bus_wr_i,
    output soc_pkg::data_t         bus_rdata_o,
    output logic                   bus_stall_o,
    output logic                   ram_rd_o,
    output logic                   ram_wr_o,
    output logic [$clog2(RAM_WORDS)-1:0] ram_idx_o,
    input  wire soc_pkg::data_t    ram_rdata_i,
    input  wire                    ram_stall_i,
    output logic                   gpio_rd_o,
    output logic                   gpio_wr_o,
    output logic [7:0]             gpio_ofs_o,
    input  wire soc_pkg::data_t    gpio_rdata_i,
    output logic                   tick_wr_o,
    input  wire soc_pkg::data_t    tick_rdata_i
);

    localparam int IW = $clog2(RAM_WORDS);

    soc_pkg::slave_sel_e sel_d, sel, sel_q;
    soc_pkg::addr_t      ram_ofs;
    logic                locked_q; // access stalled last cycle

    assign ram_ofs = bus_addr_i - soc_pkg::RAM_BASE;

    always_comb begin
        if (ram_ofs[31:2] < 30'(RAM_WORDS))
            sel_d = soc_pkg::SEL_RAM;
        else if (bus_addr_i[31:8] == soc_pkg::GPIO_BASE[31:8])
            sel_d = soc_pkg::SEL_GPIO;
        else if (bus_addr_i[31:8] == soc_pkg::TICK_BASE[31:8])
            sel_d = soc_pkg::SEL_TICK;
        else
            sel_d = soc_pkg::SEL_NONE;
    end

    // target stays locked while the access is stalled
    assign sel = locked_q ? sel_q : sel_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q    <= soc_pkg::SEL_NONE;
            locked_q <= 1'b0;
        end else begin
            sel_q    <= sel;
            locked_q <= bus_stall_o;
        end
    end

    assign ram_rd_o   = bus_rd_i && (sel == soc_pkg::SEL_RAM);
    assign ram_wr_o   = bus_wr_i && (sel == soc_pkg::SEL_RAM);
    assign ram_idx_o  = ram_ofs[IW+1:2];
    assign gpio_rd_o  = bus_rd_i && (sel == soc_pkg::SEL_GPIO);
    assign gpio_wr_o  = bus_wr_i && (sel == soc_pkg::SEL_GPIO);
    assign gpio_ofs_o = bus_addr_i[7:0];
    assign tick_wr_o  = bus_wr_i && (sel == soc_pkg::SEL_TICK);

    assign bus_stall_o = (sel == soc_pkg::SEL_RAM) && ram_stall_i;

    always_comb begin
        case (sel)
            soc_pkg::SEL_RAM:  bus_rdata_o = ram_rdata_i;
            soc_pkg::SEL_GPIO: bus_rdata_o = gpio_rdata_i;
            soc_pkg::SEL_TICK: bus_rdata_o = tick_rdata_i;
            default:           bus_rdata_o = '0; // unmapped
        endcase
    end

endmodule

`default_nettype wire

// File: ram_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module ram_ctrl #(
    parameter int RAM_WORDS = 256,
    parameter int RAM_WAIT  = 2
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          rd_i,
    input  wire                          wr_i,
    input  wire [$clog2(RAM_WORDS)-1:0]  idx_i,
    input  wire soc_pkg::be_t            be_i,
    input  wire soc_pkg::data_t          wdata_i,
    output soc_pkg::data_t               rdata_o,
    output logic                         stall_o
);

    localparam int CW = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;

    soc_pkg::data_t mem [RAM_WORDS];
    logic [CW-1:0]  wait_q;
    logic           req;
    logic           done;

    assign req     = rd_i | wr_i;
    assign stall_o = req && (wait_q != CW'(RAM_WAIT));
    assign done    = req && !stall_o;

    // counts the stall cycles of the current request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wait_q <= '0;
        else if (stall_o)
            wait_q <= wait_q + 1'b1;
        else
            wait_q <= '0;
    end

    always_ff @(posedge clk) begin
        if (done && wr_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b])
                    mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
    end

    assign rdata_o = (done && rd_i) ? mem[idx_i] : '0;

endmodule

`default_nettype wire

// File: gpio_regs.sv
`timescale 1ns/100ps
`default_nettype none

module gpio_regs (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  rd_i,
    input  wire                  wr_i,
    input  wire [7:0]            ofs_i,
    input  wire soc_pkg::be_t    be_i,
    input  wire soc_pkg::data_t  wdata_i,
    output soc_pkg::data_t       rdata_o,
    input  wire soc_pkg::data_t  gpio_in_i,
    output soc_pkg::data_t       gpio_out_o
);

    soc_pkg::data_t gpio_in_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_out_o <= '0;
        end else if (wr_i && ofs_i == soc_pkg::GPIO_OUT_OFS) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b])
                    gpio_out_o[8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
    end

    // one sync stage on the inputs
    always_ff @(posedge clk) begin
        gpio_in_q <= gpio_in_i;
    end

    always_comb begin
        rdata_o = '0;
        if (rd_i) begin
            case (ofs_i)
                soc_pkg::GPIO_OUT_OFS: rdata_o = gpio_out_o;
                soc_pkg::GPIO_IN_OFS:  rdata_o = gpio_in_q;
                default:               rdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: ticker.sv
`timescale 1ns/100ps
`default_nettype none

module ticker (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  wr_i,
    input  wire soc_pkg::data_t  wdata_i,
    output soc_pkg::data_t       rdata_o
);

    soc_pkg::data_t cnt_q;

    // free running, a bus write preloads the whole word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cnt_q <= '0;
        else if (wr_i)
            cnt_q <= wdata_i;
        else
            cnt_q <= cnt_q + 1'b1;
    end

    assign rdata_o = cnt_q;

endmodule

`default_nettype wire

// File: seg_disp.sv
`timescale 1ns/100ps
`default_nettype none

module seg_disp #(
    parameter int SCAN_DIV = 4
) (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire soc_pkg::data_t                value_i,
    output logic [soc_pkg::SEG_DIGITS-1:0]     dpy_com_o,
    output logic [7:0]                         dpy_seg_o
);

    localparam int DW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam int NW = (soc_pkg::SEG_DIGITS > 1) ? $clog2(soc_pkg::SEG_DIGITS) : 1;

    logic [DW-1:0] div_q;
    logic [NW-1:0] dig_q;
    logic [3:0]    nibble;
    logic [6:0]    seg7;  // g..a

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_q <= '0;
            dig_q <= '0;
        end else if (div_q == DW'(SCAN_DIV - 1)) begin
            div_q <= '0;
            if (dig_q == NW'(soc_pkg::SEG_DIGITS - 1))
                dig_q <= '0;
            else
                dig_q <= dig_q + 1'b1;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    assign nibble    = value_i[4*dig_q +: 4];
    assign dpy_com_o = soc_pkg::SEG_DIGITS'(1) << dig_q;

    always_comb begin
        case (nibble)
            4'h0: seg7 = 7'h3F;
            4'h1: seg7 = 7'h06;
            4'h2: seg7 = 7'h5B;
            4'h3: seg7 = 7'h4F;
            4'h4: seg7 = 7'h66;
            4'h5: seg7 = 7'h6D;
            4'h6: seg7 = 7'h7D;
            4'h7: seg7 = 7'h07;
            4'h8: seg7 = 7'h7F;
            4'h9: seg7 = 7'h6F;
            4'hA: seg7 = 7'h77;
            4'hB: seg7 = 7'h7C;
            4'hC: seg7 = 7'h39;
            4'hD: seg7 = 7'h5E;
            4'hE: seg7 = 7'h79;
            default: seg7 = 7'h71;
        endcase
    end

    assign dpy_seg_o = {seg7, 1'b0}; // dp in bit 0, never lit

endmodule

`default_nettype wire

// File: soc_bus_top.sv
`timescale 1ns/100ps
`default_nettype none

module soc_bus_top #(
    parameter int RAM_WORDS = 256,
    parameter int RAM_WAIT  = 2,
    parameter int SCAN_DIV  = 4
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire soc_pkg::addr_t  bus_addr_i,
    input  wire soc_pkg::be_t    bus_be_i,
    input  wire                  bus_rd_i,
    input  wire                  bus_wr_i,
    input  wire soc_pkg::data_t  bus_wdata_i,
    output soc_pkg::data_t       bus_rdata_o,
    output logic                 bus_stall_o,
    input  wire soc_pkg::data_t  gpio_in_i,
    output logic [15:0]          leds_o,
    output logic [7:0]           dpy_com_o,
    output logic [7:0]           dpy_seg_o
);

    logic                         ram_rd, ram_wr, ram_stall;
    logic [$clog2(RAM_WORDS)-1:0] ram_idx;
    soc_pkg::data_t               ram_rdata;
    logic                         gpio_rd, gpio_wr;
    logic [7:0]                   gpio_ofs;
    soc_pkg::data_t               gpio_rdata, gpio_out;
    logic                         tick_wr;
    soc_pkg::data_t               tick_rdata;

    dbus_decoder #(.RAM_WORDS(RAM_WORDS)) dec0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_addr_i  (bus_addr_i),
        .bus_rd_i    (bus_rd_i),
        .bus_wr_i    (bus_wr_i),
        .bus_rdata_o (bus_rdata_o),
        .bus_stall_o (bus_stall_o),
        .ram_rd_o    (ram_rd),
        .ram_wr_o    (ram_wr),
        .ram_idx_o   (ram_idx),
        .ram_rdata_i (ram_rdata),
        .ram_stall_i (ram_stall),
        .gpio_rd_o   (gpio_rd),
        .gpio_wr_o   (gpio_wr),
        .gpio_ofs_o  (gpio_ofs),
        .gpio_rdata_i(gpio_rdata),
        .tick_wr_o   (tick_wr),
        .tick_rdata_i(tick_rdata)
    );

    ram_ctrl #(.RAM_WORDS(RAM_WORDS), .RAM_WAIT(RAM_WAIT)) ram0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd_i   (ram_rd),
        .wr_i   (ram_wr),
        .idx_i  (ram_idx),
        .be_i   (bus_be_i),
        .wdata_i(bus_wdata_i),
        .rdata_o(ram_rdata),
        .stall_o(ram_stall)
    );

    gpio_regs gpio0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_i      (gpio_rd),
        .wr_i      (gpio_wr),
        .ofs_i     (gpio_ofs),
        .be_i      (bus_be_i),
        .wdata_i   (bus_wdata_i),
        .rdata_o   (gpio_rdata),
        .gpio_in_i (gpio_in_i),
        .gpio_out_o(gpio_out)
    );

    ticker tick0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_i   (tick_wr),
        .wdata_i(bus_wdata_i),
        .rdata_o(tick_rdata)
    );

    seg_disp #(.SCAN_DIV(SCAN_DIV)) seg0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .value_i  (gpio_out),
        .dpy_com_o(dpy_com_o),
        .dpy_seg_o(dpy_seg_o)
    );

    assign leds_o = gpio_out[15:0];

endmodule

`default_nettype wire

// File: tb_soc_bus.sv
`timescale 1ns/100ps
`default_nettype none

module tb_soc_bus;

    localparam int RAM_WORDS = 256;
    localparam int RAM_WAIT  = 2;
    localparam int SCAN_DIV  = 4;
    localparam int TICK_N    = 25;
    localparam int N_VECS    = 15;
    localparam int SCAN_CYC  = soc_pkg::SEG_DIGITS * SCAN_DIV;
    localparam int TIMEOUT   = N_VECS * (RAM_WAIT + 2) + SCAN_CYC + TICK_N + 200;
    localparam soc_pkg::addr_t UNMAPPED = 32'h2000_0000;
    localparam soc_pkg::addr_t GPIO_OUT = soc_pkg::GPIO_BASE + 32'(soc_pkg::GPIO_OUT_OFS);
    localparam soc_pkg::addr_t GPIO_IN  = soc_pkg::GPIO_BASE + 32'(soc_pkg::GPIO_IN_OFS);

    typedef struct packed {
        logic           wr;
        soc_pkg::addr_t addr;
        soc_pkg::be_t   be;
        soc_pkg::data_t wdata;
        soc_pkg::data_t exp;
        logic [7:0]     waits;  // expected stall cycles
    } vec_t;

    logic           clk;
    logic           rst_n;
    soc_pkg::addr_t bus_addr_i;
    soc_pkg::be_t   bus_be_i;
    logic           bus_rd_i;
    logic           bus_wr_i;
    soc_pkg::data_t bus_wdata_i;
    soc_pkg::data_t bus_rdata_o;
    logic           bus_stall_o;
    soc_pkg::data_t gpio_in_i;
    logic [15:0]    leds_o;
    logic [7:0]     dpy_com_o;
    logic [7:0]     dpy_seg_o;

    vec_t vecs [$];
    int   errors;
    int   tests_ok;
    int   tests_bad;
    int   cycles;

    // g..a for hex digits 0..F
    logic [6:0] seg_tab [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                                 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

    soc_bus_top #(.RAM_WORDS(RAM_WORDS), .RAM_WAIT(RAM_WAIT), .SCAN_DIV(SCAN_DIV)) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_addr_i (bus_addr_i),
        .bus_be_i   (bus_be_i),
        .bus_rd_i   (bus_rd_i),
        .bus_wr_i   (bus_wr_i),
        .bus_wdata_i(bus_wdata_i),
        .bus_rdata_o(bus_rdata_o),
        .bus_stall_o(bus_stall_o),
        .gpio_in_i  (gpio_in_i),
        .leds_o     (leds_o),
        .dpy_com_o  (dpy_com_o),
        .dpy_seg_o  (dpy_seg_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic check_data(input string name, input soc_pkg::data_t exp,
                              input soc_pkg::data_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_wait(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_seg(input int digit, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: dpy_seg_o (digit %0d) expected %h, got %h",
                     $time, digit, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        if (errors == err_start) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    task automatic add_vec(input logic wr, input soc_pkg::addr_t addr, input soc_pkg::be_t be,
                           input soc_pkg::data_t wdata, input soc_pkg::data_t exp,
                           input int waits);
        vecs.push_back({wr, addr, be, wdata, exp, 8'(waits)});
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // entered 2 ns after a rising edge, returns at the same point after completion
    task automatic bus_access(input logic wr, input soc_pkg::addr_t addr,
                              input soc_pkg::be_t be, input soc_pkg::data_t wdata,
                              output soc_pkg::data_t rdata, output int waits);
        bus_addr_i  = addr;
        bus_be_i    = be;
        bus_wdata_i = wdata;
        bus_rd_i    = !wr;
        bus_wr_i    = wr;
        waits       = 0;
        @(negedge clk);
        while (bus_stall_o) begin
            waits++;
            @(negedge clk);
        end
        rdata = bus_rdata_o;
        @(posedge clk);
        #2;
        bus_rd_i = 1'b0;
        bus_wr_i = 1'b0;
    endtask

    task automatic scan_display(input soc_pkg::data_t value);
        logic [soc_pkg::SEG_DIGITS-1:0] seen;
        int k;
        seen = '0;
        repeat (SCAN_CYC) begin
            @(negedge clk);
            if (!$onehot(dpy_com_o)) begin
                errors++;
                $display("digit select is not one-hot at %0t: %b", $time, dpy_com_o);
            end else begin
                k = $clog2(dpy_com_o);
                seen[k] = 1'b1;
                check_seg(k, {seg_tab[value[4*k +: 4]], 1'b0}, dpy_seg_o);
            end
        end
        if (seen != '1) begin
            errors++;
            $display("the scan did not visit every digit, seen %b", seen);
        end
        @(posedge clk);
        #2;
    endtask

    initial begin : main
        soc_pkg::data_t rdata;
        soc_pkg::data_t word;
        soc_pkg::data_t pre;
        int             waits;
        int             err0;
        vec_t           v;
        word        = $urandom(84691); // seeds the generator
        rst_n       = 1'b0;
        bus_addr_i  = '0;
        bus_be_i    = '0;
        bus_rd_i    = 1'b0;
        bus_wr_i    = 1'b0;
        bus_wdata_i = '0;
        gpio_in_i   = '0;
        errors      = 0;
        tests_ok    = 0;
        tests_bad   = 0;

        err0 = errors;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_data("dpy_com_o", 32'h1, 32'(dpy_com_o));
        check_data("bus_stall_o", 32'h0, 32'(bus_stall_o));
        check_data("leds_o", 32'h0, 32'(leds_o));
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;
        finish_test("reset values", err0);

        // ram words, byte merges and unmapped accesses
        add_vec(1'b1, 32'h0000_0000, 4'hF, 32'h0123_4567, 32'h0, RAM_WAIT);
        add_vec(1'b1, 32'h0000_0004, 4'hF, 32'h89AB_CDEF, 32'h0, RAM_WAIT);
        add_vec(1'b1, 32'h0000_03FC, 4'hF, 32'hA5A5_5A5A, 32'h0, RAM_WAIT);
        add_vec(1'b0, 32'h0000_0000, 4'hF, 32'h0, 32'h0123_4567, RAM_WAIT);
        add_vec(1'b0, 32'h0000_0004, 4'hF, 32'h0, 32'h89AB_CDEF, RAM_WAIT);
        add_vec(1'b0, 32'h0000_03FC, 4'hF, 32'h0, 32'hA5A5_5A5A, RAM_WAIT);
        add_vec(1'b1, 32'h0000_0010, 4'hF, 32'hDEAD_BEEF, 32'h0, RAM_WAIT);
        add_vec(1'b1, 32'h0000_0010, 4'b0101, 32'h1122_3344, 32'h0, RAM_WAIT);
        add_vec(1'b0, 32'h0000_0010, 4'hF, 32'h0, 32'hDE22_BE44, RAM_WAIT);
        add_vec(1'b1, 32'h0000_0010, 4'b1010, 32'hCAFE_F00D, 32'h0, RAM_WAIT);
        add_vec(1'b0, 32'h0000_0010, 4'hF, 32'h0, 32'hCA22_F044, RAM_WAIT);
        add_vec(1'b0, UNMAPPED, 4'hF, 32'h0, 32'h0, 0);
        add_vec(1'b1, UNMAPPED, 4'hF, 32'hFFFF_FFFF, 32'h0, 0);
        add_vec(1'b1, 32'h1FD0_F200, 4'hF, 32'hFFFF_FFFF, 32'h0, 0);
        add_vec(1'b0, 32'h0000_0400, 4'hF, 32'h0, 32'h0, 0); // one past the ram

        foreach (vecs[i]) begin
            err0 = errors;
            v = vecs[i];
            bus_access(v.wr, v.addr, v.be, v.wdata, rdata, waits);
            check_wait("bus_stall_o cycles", int'(v.waits), waits);
            if (!v.wr)
                check_data("bus_rdata_o", v.exp, rdata);
            finish_test($sformatf("vector %0d %s %h", i, v.wr ? "wr" : "rd", v.addr), err0);
        end

        err0 = errors;
        word = $urandom;
        bus_access(1'b1, GPIO_OUT, 4'hF, word, rdata, waits);
        check_data("leds_o", {16'h0, word[15:0]}, 32'(leds_o));
        bus_access(1'b0, GPIO_OUT, 4'hF, 32'h0, rdata, waits);
        check_data("gpio out readback", word, rdata);
        pre       = $urandom;
        gpio_in_i = pre;
        idle(2);
        bus_access(1'b0, GPIO_IN, 4'hF, 32'h0, rdata, waits);
        check_data("gpio in readback", pre, rdata);
        finish_test("gpio", err0);

        err0 = errors;
        scan_display(word);
        finish_test("display scan", err0);

        err0 = errors;
        pre = $urandom;
        bus_access(1'b1, soc_pkg::TICK_BASE, 4'hF, pre, rdata, waits);
        idle(TICK_N);
        bus_access(1'b0, soc_pkg::TICK_BASE, 4'hF, 32'h0, rdata, waits);
        check_data("ticker", pre + TICK_N, rdata);
        finish_test("ticker preload", err0);

        // unmapped write takes one cycle, the ticker keeps counting through it
        err0 = errors;
        pre = $urandom;
        bus_access(1'b1, soc_pkg::TICK_BASE, 4'hF, pre, rdata, waits);
        bus_access(1'b1, UNMAPPED, 4'hF, 32'hFFFF_FFFF, rdata, waits);
        check_wait("bus_stall_o cycles", 0, waits);
        bus_access(1'b0, soc_pkg::TICK_BASE, 4'hF, 32'h0, rdata, waits);
        check_data("ticker", pre + 1, rdata);
        bus_access(1'b0, GPIO_OUT, 4'hF, 32'h0, rdata, waits);
        check_data("gpio out readback", word, rdata);
        bus_access(1'b0, 32'h0000_0000, 4'hF, 32'h0, rdata, waits);
        check_data("ram word 0", 32'h0123_4567, rdata);
        bus_access(1'b0, 32'h0000_0010, 4'hF, 32'h0, rdata, waits);
        check_data("ram word 4", 32'hCA22_F044, rdata);
        finish_test("unmapped write", err0);

        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: soc_bus_top.f
soc_pkg.sv
dbus_decoder.sv
ram_ctrl.sv
gpio_regs.sv
ticker.sv
seg_disp.sv
soc_bus_top.sv
tb_soc_bus.sv

// File: Bender.yml
package:
  name: soc_bus

sources:
  - files:
      - soc_pkg.sv
      - dbus_decoder.sv
      - ram_ctrl.sv
      - gpio_regs.sv
      - ticker.sv
      - seg_disp.sv
      - soc_bus_top.sv
  - target: test
    files:
      - tb_soc_bus.sv
